//--- sources.f
common/mem_types_pkg.sv
common/mem_map_pkg.sv
ram_controller/ram_bank.sv
ram_controller/ram_controller.sv
verilog/uart_status.sv
verilog/mem_arbiter.sv
verilog/mem_subsystem.sv
dv/mem_subsystem_checker.sv
dv/mem_subsystem_tb.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - common/mem_types_pkg.sv
      - common/mem_map_pkg.sv
      - ram_controller/ram_bank.sv
      - ram_controller/ram_controller.sv
      - verilog/uart_status.sv
      - verilog/mem_arbiter.sv
      - verilog/mem_subsystem.sv
  - target: test
    files:
      - dv/mem_subsystem_checker.sv
      - dv/mem_subsystem_tb.sv

//--- dv/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

	import mem_types_pkg::*;
	import mem_map_pkg::*;

	localparam int FIFO_DEPTH      = 2;
	localparam int RAM1_LATENCY    = 2;
	localparam int RAM2_LATENCY    = 3;
	localparam int BANK_DEPTH_LOG2 = 8;
	localparam int BURST_LEN       = 12;
	localparam int CYCLES_PER_ROW  = FIFO_DEPTH * 2 * (RAM2_LATENCY + 2);

	typedef enum logic {KIND_WORD, KIND_STATUS} kind_t;

	logic       ram1_work_done;
	logic       reset;
	logic       fetch_req_valid;
	logic       fetch_req_we;
	mem_addr_t  fetch_req_addr;
	mem_word_t  fetch_req_wdata;
	logic       fetch_credit;
	logic       fetch_resp_valid;
	mem_word_t  fetch_resp_rdata;
	logic       ls_req_valid;
	logic       ls_req_we;
	mem_addr_t  ls_req_addr;
	mem_word_t  ls_req_wdata;
	logic       ls_credit;
	logic       ls_resp_valid;
	mem_word_t  ls_resp_rdata;
	logic       rx_valid;
	uart_byte_t rx_data;

	// Stimulus table, one entry per row across all queues
	string      row_name [$];
	int         row_port [$];
	logic       row_we [$];
	mem_addr_t  row_addr [$];
	mem_word_t  row_wdata [$];
	logic       row_inject [$];
	uart_byte_t row_rx [$];
	kind_t      row_kind [$];

	// Reference model, both banks side by side
	mem_word_t  ref_mem [2 * (2 ** BANK_DEPTH_LOG2)];
	logic       ref_rx_ready = 1'b0;
	uart_byte_t ref_rx_byte = '0;

	// Expected responses, index 0 fetch and 1 load/store
	mem_word_t exp_val [2][$];
	kind_t     exp_kind [2][$];
	string     exp_name [2][$];

	int          credit_count [2];
	int          cycle_count = 0;
	int          cycle_limit = 1000;
	logic [31:0] lcg_state = 32'hd6c6_e7b6;

	mem_subsystem #(
		.FIFO_DEPTH     (FIFO_DEPTH),
		.RAM1_LATENCY   (RAM1_LATENCY),
		.RAM2_LATENCY   (RAM2_LATENCY),
		.BANK_DEPTH_LOG2(BANK_DEPTH_LOG2)
	) uut (
		.ram1_work_done  (ram1_work_done),
		.reset           (reset),
		.fetch_req_valid (fetch_req_valid),
		.fetch_req_we    (fetch_req_we),
		.fetch_req_addr  (fetch_req_addr),
		.fetch_req_wdata (fetch_req_wdata),
		.fetch_credit    (fetch_credit),
		.fetch_resp_valid(fetch_resp_valid),
		.fetch_resp_rdata(fetch_resp_rdata),
		.ls_req_valid    (ls_req_valid),
		.ls_req_we       (ls_req_we),
		.ls_req_addr     (ls_req_addr),
		.ls_req_wdata    (ls_req_wdata),
		.ls_credit       (ls_credit),
		.ls_resp_valid   (ls_resp_valid),
		.ls_resp_rdata   (ls_resp_rdata),
		.rx_valid        (rx_valid),
		.rx_data         (rx_data)
	);

	initial ram1_work_done = 1'b0;
	always #10 ram1_work_done = ~ram1_work_done;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input mem_word_t expected,
			input mem_word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_status(input string name, input mem_word_t expected,
			input mem_word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h (ready %b vs %b)",
				name, expected, actual, expected[1], actual[1]);
			stop_with_failure();
		end
	endtask

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// Bank select bit on top, then the low bits the bank decodes
	function automatic int ref_index(input mem_addr_t addr);
		return int'({addr[BANK_SELECT_BIT], addr[BANK_DEPTH_LOG2-1:0]});
	endfunction

	// Fill, mode one, ready flag, trailing set bit
	function automatic mem_word_t expected_status(input logic ready);
		return {STATUS_FILL, 2'b01, ready, 1'b1};
	endfunction

	function automatic mem_word_t model_request(input logic we, input mem_addr_t addr,
			input mem_word_t wdata);
		mem_word_t result;
		if (we) begin
			result = wdata;
			if (addr != UART_DATA_ADDR && addr != UART_STATUS_ADDR) begin
				ref_mem[ref_index(addr)] = wdata;
			end
		end else if (addr == UART_STATUS_ADDR) begin
			result = expected_status(ref_rx_ready);
		end else if (addr == UART_DATA_ADDR) begin
			result = {8'h00, ref_rx_byte};
			ref_rx_ready = 1'b0;
		end else begin
			result = ref_mem[ref_index(addr)];
		end
		return result;
	endfunction

	task automatic add_row(input string name, input int port, input logic we,
			input mem_addr_t addr, input mem_word_t wdata, input logic inject,
			input uart_byte_t rx, input kind_t kind);
		row_name.push_back(name);
		row_port.push_back(port);
		row_we.push_back(we);
		row_addr.push_back(addr);
		row_wdata.push_back(wdata);
		row_inject.push_back(inject);
		row_rx.push_back(rx);
		row_kind.push_back(kind);
	endtask

	task automatic drive_port(input int port, input logic valid, input logic we,
			input mem_addr_t addr, input mem_word_t wdata);
		if (port == 0) begin
			fetch_req_valid <= valid;
			fetch_req_we    <= we;
			fetch_req_addr  <= addr;
			fetch_req_wdata <= wdata;
		end else begin
			ls_req_valid <= valid;
			ls_req_we    <= we;
			ls_req_addr  <= addr;
			ls_req_wdata <= wdata;
		end
	endtask

	// One valid cycle per request, only with a credit in hand
	task automatic issue(input int port, input string name, input logic we,
			input mem_addr_t addr, input mem_word_t wdata, input kind_t kind);
		mem_word_t expected;
		@(posedge ram1_work_done);
		while (credit_count[port] == 0) begin
			drive_port(port, 1'b0, 1'b0, '0, '0);
			@(posedge ram1_work_done);
		end
		expected = model_request(we, addr, wdata);
		exp_val[port].push_back(expected);
		exp_kind[port].push_back(kind);
		exp_name[port].push_back(name);
		drive_port(port, 1'b1, we, addr, wdata);
	endtask

	task automatic release_port(input int port);
		@(posedge ram1_work_done);
		drive_port(port, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic wait_drained();
		while (exp_val[0].size() != 0 || exp_val[1].size() != 0) begin
			@(posedge ram1_work_done);
		end
	endtask

	task automatic inject_byte(input uart_byte_t value);
		@(posedge ram1_work_done);
		rx_valid <= 1'b1;
		rx_data  <= value;
		ref_rx_ready = 1'b1;
		ref_rx_byte  = value;
		@(posedge ram1_work_done);
		rx_valid <= 1'b0;
	endtask

	task automatic build_table();
		logic [15:0] rnd;
		mem_addr_t   addr;
		mem_word_t   data;
		int          port;
		add_row("ram1_write", 1, 1'b1, 16'h8010, 16'hA5A5, 1'b0, '0, KIND_WORD);
		add_row("ram1_read", 1, 1'b0, 16'h8010, '0, 1'b0, '0, KIND_WORD);
		add_row("ram2_write", 0, 1'b1, 16'h0010, 16'h5A5A, 1'b0, '0, KIND_WORD);
		add_row("ram2_read", 0, 1'b0, 16'h0010, '0, 1'b0, '0, KIND_WORD);
		// Same low bits, only bit 15 differs
		add_row("split_write_hi", 1, 1'b1, 16'h8023, 16'h1111, 1'b0, '0, KIND_WORD);
		add_row("split_write_lo", 0, 1'b1, 16'h0023, 16'h2222, 1'b0, '0, KIND_WORD);
		add_row("split_read_hi", 0, 1'b0, 16'h8023, '0, 1'b0, '0, KIND_WORD);
		add_row("split_read_lo", 1, 1'b0, 16'h0023, '0, 1'b0, '0, KIND_WORD);
		add_row("ram1_read_again", 0, 1'b0, 16'h8010, '0, 1'b0, '0, KIND_WORD);
		// UART register
		add_row("status_empty", 1, 1'b0, UART_STATUS_ADDR, '0, 1'b0, '0, KIND_STATUS);
		add_row("status_ready", 1, 1'b0, UART_STATUS_ADDR, '0, 1'b1, 8'h3C, KIND_STATUS);
		add_row("data_read", 0, 1'b0, UART_DATA_ADDR, '0, 1'b0, '0, KIND_WORD);
		add_row("status_cleared", 1, 1'b0, UART_STATUS_ADDR, '0, 1'b0, '0, KIND_STATUS);
		add_row("uart_write_echo", 1, 1'b1, UART_DATA_ADDR, 16'h1234, 1'b0, '0, KIND_WORD);
		add_row("data_read_high", 1, 1'b0, UART_DATA_ADDR, '0, 1'b1, 8'hE7, KIND_WORD);
		add_row("status_final", 0, 1'b0, UART_STATUS_ADDR, '0, 1'b0, '0, KIND_STATUS);
		// Random data rows, never on the UART addresses
		for (int i = 0; i < 8; i++) begin
			rnd  = next_random();
			addr = {rnd[15], 7'h00, rnd[7:0]};
			data = next_random();
			port = int'(rnd[8]);
			add_row($sformatf("random_write_%0d", i), port, 1'b1, addr, data,
				1'b0, '0, KIND_WORD);
			add_row($sformatf("random_read_%0d", i), 1 - port, 1'b0, addr, '0,
				1'b0, '0, KIND_WORD);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bursts at full credit on both ports
	////////////////////////////////////////////////////////////

	// Fetch only reads ram2, load/store only touches ram1
	task automatic fetch_burst();
		for (int i = 0; i < BURST_LEN; i++) begin
			issue(0, $sformatf("fetch_burst_%0d", i), 1'b0,
				(i % 2 == 0) ? 16'h0010 : 16'h0023, '0, KIND_WORD);
		end
		release_port(0);
	endtask

	task automatic ls_burst();
		logic [15:0] rnd;
		mem_addr_t   addr;
		mem_word_t   data;
		for (int i = 0; i < BURST_LEN; i += 2) begin
			rnd  = next_random();
			addr = 16'h8040 | mem_addr_t'(rnd[3:0]);
			data = next_random();
			issue(1, $sformatf("ls_burst_write_%0d", i), 1'b1, addr, data, KIND_WORD);
			issue(1, $sformatf("ls_burst_read_%0d", i), 1'b0, addr, '0, KIND_WORD);
		end
		release_port(1);
	endtask

	////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////

	task automatic track_credit(input int port, input logic valid, input logic credit);
		credit_count[port] = credit_count[port] + int'(credit) - int'(valid);
		if (credit_count[port] > FIFO_DEPTH) begin
			$display("Port %0d got back more credits than it spent", port);
			stop_with_failure();
		end
	endtask

	task automatic take_response(input int port, input mem_word_t rdata);
		if (exp_val[port].size() == 0) begin
			$display("Port %0d got a response with no request outstanding", port);
			stop_with_failure();
		end else begin
			if (exp_kind[port][0] == KIND_STATUS) begin
				check_status(exp_name[port][0], exp_val[port][0], rdata);
			end else begin
				check_word(exp_name[port][0], exp_val[port][0], rdata);
			end
			void'(exp_val[port].pop_front());
			void'(exp_kind[port].pop_front());
			void'(exp_name[port].pop_front());
			// Every answered request has its credit back by now
			if (FIFO_DEPTH - credit_count[port] > exp_val[port].size()) begin
				$display("Port %0d got a response before its credit came back", port);
				stop_with_failure();
			end
		end
	endtask

	// Outputs sampled mid-cycle
	always @(negedge ram1_work_done) begin
		if (reset) begin
			credit_count[0] = FIFO_DEPTH;
			credit_count[1] = FIFO_DEPTH;
		end else begin
			track_credit(0, fetch_req_valid, fetch_credit);
			track_credit(1, ls_req_valid, ls_credit);
			if (fetch_resp_valid) begin
				take_response(0, fetch_resp_rdata);
			end
			if (ls_resp_valid) begin
				take_response(1, ls_resp_rdata);
			end
		end
	end

	always @(posedge ram1_work_done) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles with responses still missing", cycle_count);
			stop_with_failure();
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset           = 1'b1;
		fetch_req_valid = 1'b0;
		fetch_req_we    = 1'b0;
		fetch_req_addr  = '0;
		fetch_req_wdata = '0;
		ls_req_valid    = 1'b0;
		ls_req_we       = 1'b0;
		ls_req_addr     = '0;
		ls_req_wdata    = '0;
		rx_valid        = 1'b0;
		rx_data         = '0;
		build_table();
		cycle_limit = (row_name.size() + 2 * BURST_LEN) * CYCLES_PER_ROW + 200;
		repeat (10) @(posedge ram1_work_done);
		reset <= 1'b0;

		// Table rows one at a time so the UART model stays exact
		for (int i = 0; i < row_name.size(); i++) begin
			if (row_inject[i]) begin
				inject_byte(row_rx[i]);
			end
			issue(row_port[i], row_name[i], row_we[i], row_addr[i], row_wdata[i],
				row_kind[i]);
			release_port(row_port[i]);
			wait_drained();
		end

		fork
			fetch_burst();
			ls_burst();
		join
		wait_drained();

		if (credit_count[0] != FIFO_DEPTH || credit_count[1] != FIFO_DEPTH) begin
			$display("Credits not all returned at the end of the run");
			stop_with_failure();
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

//--- dv/mem_subsystem_checker.sv
`timescale 1ns/1ps

module mem_subsystem_checker (
	input logic       ram1_work_done,
	input logic       reset,
	input logic       cmd_valid,
	input logic       cmd_ready,
	input logic [1:0] not_empty,
	input logic [1:0] pop,
	input logic       fetch_credit,
	input logic       ls_credit,
	input logic       done_valid
);

	// A command sits in the controller
	logic in_flight;

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			in_flight <= 1'b0;
		end else if (cmd_valid && cmd_ready) begin
			in_flight <= 1'b1;
		end else if (done_valid) begin
			in_flight <= 1'b0;
		end
	end

	pop_needs_entry: assert property (@(posedge ram1_work_done) disable iff (reset)
		(pop & ~not_empty) == 2'b00)
		else $error("pop from an empty request FIFO");

	fetch_credit_after_pop: assert property (@(posedge ram1_work_done) disable iff (reset)
		fetch_credit |-> $past(pop[0]))
		else $error("fetch credit without a pop");

	ls_credit_after_pop: assert property (@(posedge ram1_work_done) disable iff (reset)
		ls_credit |-> $past(pop[1]))
		else $error("load/store credit without a pop");

	done_after_transfer: assert property (@(posedge ram1_work_done) disable iff (reset)
		done_valid |-> in_flight)
		else $error("done_valid without a transferred command");

endmodule

bind mem_arbiter mem_subsystem_checker u_checker (
	.ram1_work_done(ram1_work_done),
	.reset         (reset),
	.cmd_valid     (cmd_valid),
	.cmd_ready     (cmd_ready),
	.not_empty     (not_empty),
	.pop           (pop),
	.fetch_credit  (fetch_credit),
	.ls_credit     (ls_credit),
	.done_valid    (done_valid)
);

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
	parameter int FIFO_DEPTH      = 2,
	parameter int RAM1_LATENCY    = 2,
	parameter int RAM2_LATENCY    = 3,
	parameter int BANK_DEPTH_LOG2 = 8
) (
	input  logic                      ram1_work_done,
	input  logic                      reset,

	input  logic                      fetch_req_valid,
	input  logic                      fetch_req_we,
	input  mem_types_pkg::mem_addr_t  fetch_req_addr,
	input  mem_types_pkg::mem_word_t  fetch_req_wdata,
	output logic                      fetch_credit,
	output logic                      fetch_resp_valid,
	output mem_types_pkg::mem_word_t  fetch_resp_rdata,

	input  logic                      ls_req_valid,
	input  logic                      ls_req_we,
	input  mem_types_pkg::mem_addr_t  ls_req_addr,
	input  mem_types_pkg::mem_word_t  ls_req_wdata,
	output logic                      ls_credit,
	output logic                      ls_resp_valid,
	output mem_types_pkg::mem_word_t  ls_resp_rdata,

	input  logic                      rx_valid,
	input  mem_types_pkg::uart_byte_t rx_data
);

	import mem_types_pkg::*;

	// Arbiter to controller
	logic      cmd_valid;
	logic      cmd_we;
	mem_addr_t cmd_addr;
	mem_word_t cmd_wdata;
	port_tag_t cmd_tag;
	logic      cmd_ready;
	logic      done_valid;
	mem_word_t done_rdata;
	port_tag_t done_tag;

	// Controller to banks
	logic      ram1_need_to_work;
	logic      ram2_need_to_work;
	logic      bank_we;
	mem_addr_t bank_addr;
	mem_word_t bank_wdata;
	logic      ram1_bank_done;
	mem_word_t ram1_feedback;
	logic      ram2_bank_done;
	mem_word_t ram2_feedback;

	// Controller to UART register
	logic       uart_data_read;
	logic       rx_ready;
	uart_byte_t rx_byte;

	mem_arbiter #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_arbiter (
		.ram1_work_done  (ram1_work_done),
		.reset           (reset),
		.fetch_req_valid (fetch_req_valid),
		.fetch_req_we    (fetch_req_we),
		.fetch_req_addr  (fetch_req_addr),
		.fetch_req_wdata (fetch_req_wdata),
		.fetch_credit    (fetch_credit),
		.fetch_resp_valid(fetch_resp_valid),
		.fetch_resp_rdata(fetch_resp_rdata),
		.ls_req_valid    (ls_req_valid),
		.ls_req_we       (ls_req_we),
		.ls_req_addr     (ls_req_addr),
		.ls_req_wdata    (ls_req_wdata),
		.ls_credit       (ls_credit),
		.ls_resp_valid   (ls_resp_valid),
		.ls_resp_rdata   (ls_resp_rdata),
		.cmd_valid       (cmd_valid),
		.cmd_we          (cmd_we),
		.cmd_addr        (cmd_addr),
		.cmd_wdata       (cmd_wdata),
		.cmd_tag         (cmd_tag),
		.cmd_ready       (cmd_ready),
		.done_valid      (done_valid),
		.done_rdata      (done_rdata),
		.done_tag        (done_tag)
	);

	ram_controller u_controller (
		.ram1_work_done   (ram1_work_done),
		.reset            (reset),
		.cmd_valid        (cmd_valid),
		.cmd_we           (cmd_we),
		.cmd_addr         (cmd_addr),
		.cmd_wdata        (cmd_wdata),
		.cmd_tag          (cmd_tag),
		.cmd_ready        (cmd_ready),
		.done_valid       (done_valid),
		.done_rdata       (done_rdata),
		.done_tag         (done_tag),
		.ram1_bank_done   (ram1_bank_done),
		.ram1_feedback    (ram1_feedback),
		.ram2_bank_done   (ram2_bank_done),
		.ram2_feedback    (ram2_feedback),
		.ram1_need_to_work(ram1_need_to_work),
		.ram2_need_to_work(ram2_need_to_work),
		.bank_we          (bank_we),
		.bank_addr        (bank_addr),
		.bank_wdata       (bank_wdata),
		.rx_ready         (rx_ready),
		.rx_byte          (rx_byte),
		.uart_data_read   (uart_data_read)
	);

	// Data RAM
	ram_bank #(
		.LATENCY        (RAM1_LATENCY),
		.BANK_DEPTH_LOG2(BANK_DEPTH_LOG2)
	) u_ram1 (
		.ram1_work_done(ram1_work_done),
		.reset         (reset),
		.need_to_work  (ram1_need_to_work),
		.bank_we       (bank_we),
		.bank_addr     (bank_addr),
		.bank_wdata    (bank_wdata),
		.bank_done     (ram1_bank_done),
		.feedback      (ram1_feedback)
	);

	// Instruction RAM
	ram_bank #(
		.LATENCY        (RAM2_LATENCY),
		.BANK_DEPTH_LOG2(BANK_DEPTH_LOG2)
	) u_ram2 (
		.ram1_work_done(ram1_work_done),
		.reset         (reset),
		.need_to_work  (ram2_need_to_work),
		.bank_we       (bank_we),
		.bank_addr     (bank_addr),
		.bank_wdata    (bank_wdata),
		.bank_done     (ram2_bank_done),
		.feedback      (ram2_feedback)
	);

	uart_status u_uart (
		.ram1_work_done(ram1_work_done),
		.reset         (reset),
		.rx_valid      (rx_valid),
		.rx_data       (rx_data),
		.uart_data_read(uart_data_read),
		.rx_ready      (rx_ready),
		.rx_byte       (rx_byte)
	);

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
	parameter int FIFO_DEPTH = 2
) (
	input  logic                     ram1_work_done,
	input  logic                     reset,

	input  logic                     fetch_req_valid,
	input  logic                     fetch_req_we,
	input  mem_types_pkg::mem_addr_t fetch_req_addr,
	input  mem_types_pkg::mem_word_t fetch_req_wdata,
	output logic                     fetch_credit,
	output logic                     fetch_resp_valid,
	output mem_types_pkg::mem_word_t fetch_resp_rdata,

	input  logic                     ls_req_valid,
	input  logic                     ls_req_we,
	input  mem_types_pkg::mem_addr_t ls_req_addr,
	input  mem_types_pkg::mem_word_t ls_req_wdata,
	output logic                     ls_credit,
	output logic                     ls_resp_valid,
	output mem_types_pkg::mem_word_t ls_resp_rdata,

	output logic                     cmd_valid,
	output logic                     cmd_we,
	output mem_types_pkg::mem_addr_t cmd_addr,
	output mem_types_pkg::mem_word_t cmd_wdata,
	output mem_types_pkg::port_tag_t cmd_tag,
	input  logic                     cmd_ready,

	input  logic                     done_valid,
	input  mem_types_pkg::mem_word_t done_rdata,
	input  mem_types_pkg::port_tag_t done_tag
);

	import mem_types_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Index 0 is the fetch port, index 1 the load/store port
	logic [1:0] push_valid;
	logic [1:0] push_we;
	mem_addr_t  push_addr [2];
	mem_word_t  push_wdata [2];

	logic [FIFO_DEPTH-1:0] fifo_we [2];
	mem_addr_t             fifo_addr [2][FIFO_DEPTH];
	mem_word_t             fifo_wdata [2][FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr [2];
	logic [PTR_W-1:0] rd_ptr [2];
	logic [CNT_W-1:0] count [2];

	logic [1:0] not_empty;
	logic [1:0] pop;
	logic [1:0] credit_q;
	port_tag_t  rr_next;
	port_tag_t  grant;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign push_valid    = {ls_req_valid, fetch_req_valid};
	assign push_we       = {ls_req_we, fetch_req_we};
	assign push_addr[0]  = fetch_req_addr;
	assign push_addr[1]  = ls_req_addr;
	assign push_wdata[0] = fetch_req_wdata;
	assign push_wdata[1] = ls_req_wdata;

	assign not_empty[0] = (count[0] != '0);
	assign not_empty[1] = (count[1] != '0);

	////////////////////////////////////////////////////////////
	// Round-robin grant
	////////////////////////////////////////////////////////////

	// Favoured port wins if it has something, else the other one
	always_comb begin
		if (not_empty[rr_next]) begin
			grant = rr_next;
		end else begin
			grant = ~rr_next;
		end
	end

	assign cmd_valid = |not_empty;
	assign cmd_tag   = grant;
	assign cmd_we    = fifo_we[grant][rd_ptr[grant]];
	assign cmd_addr  = fifo_addr[grant][rd_ptr[grant]];
	assign cmd_wdata = fifo_wdata[grant][rd_ptr[grant]];

	assign pop[0] = cmd_valid && cmd_ready && (grant == TAG_FETCH);
	assign pop[1] = cmd_valid && cmd_ready && (grant == TAG_LS);

	////////////////////////////////////////////////////////////
	// Request FIFOs
	////////////////////////////////////////////////////////////

	// Credits keep pushes below FIFO_DEPTH, no full check needed
	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			for (int p = 0; p < 2; p++) begin
				wr_ptr[p] <= '0;
				rd_ptr[p] <= '0;
				count[p]  <= '0;
			end
			rr_next  <= TAG_FETCH;
			credit_q <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (push_valid[p]) begin
					wr_ptr[p] <= next_ptr(wr_ptr[p]);
				end
				if (pop[p]) begin
					rd_ptr[p] <= next_ptr(rd_ptr[p]);
				end
				count[p] <= count[p] + CNT_W'(push_valid[p]) - CNT_W'(pop[p]);
			end
			if (cmd_valid && cmd_ready) begin
				rr_next <= ~grant;
			end
			// Credit goes back the cycle after the pop
			credit_q <= pop;
		end
	end

	always_ff @(posedge ram1_work_done) begin
		for (int p = 0; p < 2; p++) begin
			if (push_valid[p]) begin
				fifo_we[p][wr_ptr[p]]    <= push_we[p];
				fifo_addr[p][wr_ptr[p]]  <= push_addr[p];
				fifo_wdata[p][wr_ptr[p]] <= push_wdata[p];
			end
		end
	end

	assign fetch_credit = credit_q[0];
	assign ls_credit    = credit_q[1];

	// Results steered by tag, same cycle
	assign fetch_resp_valid = done_valid && (done_tag == TAG_FETCH);
	assign ls_resp_valid    = done_valid && (done_tag == TAG_LS);
	assign fetch_resp_rdata = done_rdata;
	assign ls_resp_rdata    = done_rdata;

endmodule

//--- verilog/uart_status.sv
`timescale 1ns/1ps

module uart_status (
	input  logic                      ram1_work_done,
	input  logic                      reset,

	input  logic                      rx_valid,
	input  mem_types_pkg::uart_byte_t rx_data,
	input  logic                      uart_data_read,

	output logic                      rx_ready,
	output mem_types_pkg::uart_byte_t rx_byte
);

	// Receive has priority over a read in the same cycle
	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			rx_ready <= 1'b0;
		end else if (rx_valid) begin
			rx_ready <= 1'b1;
		end else if (uart_data_read) begin
			rx_ready <= 1'b0;
		end
	end

	// Byte just holds the last received value
	always_ff @(posedge ram1_work_done) begin
		if (rx_valid) begin
			rx_byte <= rx_data;
		end
	end

endmodule

//--- ram_controller/ram_controller.sv
`timescale 1ns/1ps

module ram_controller (
	input  logic                      ram1_work_done,
	input  logic                      reset,

	input  logic                      cmd_valid,
	input  logic                      cmd_we,
	input  mem_types_pkg::mem_addr_t  cmd_addr,
	input  mem_types_pkg::mem_word_t  cmd_wdata,
	input  mem_types_pkg::port_tag_t  cmd_tag,
	output logic                      cmd_ready,

	output logic                      done_valid,
	output mem_types_pkg::mem_word_t  done_rdata,
	output mem_types_pkg::port_tag_t  done_tag,

	input  logic                      ram1_bank_done,
	input  mem_types_pkg::mem_word_t  ram1_feedback,
	input  logic                      ram2_bank_done,
	input  mem_types_pkg::mem_word_t  ram2_feedback,

	output logic                      ram1_need_to_work,
	output logic                      ram2_need_to_work,
	output logic                      bank_we,
	output mem_types_pkg::mem_addr_t  bank_addr,
	output mem_types_pkg::mem_word_t  bank_wdata,

	input  logic                      rx_ready,
	input  mem_types_pkg::uart_byte_t rx_byte,
	output logic                      uart_data_read
);

	import mem_types_pkg::*;
	import mem_map_pkg::*;

	ctrl_state_t state;

	// Command held for the whole access
	logic      we_q;
	mem_addr_t addr_q;
	mem_word_t wdata_q;
	port_tag_t tag_q;

	logic      sel_ram1;
	logic      sel_done;
	mem_word_t sel_feedback;
	mem_word_t uart_word;

	assign cmd_ready = (state == CTRL_IDLE);

	// Banks see the latched command directly
	assign bank_we    = we_q;
	assign bank_addr  = addr_q;
	assign bank_wdata = wdata_q;

	assign sel_ram1     = addr_q[BANK_SELECT_BIT];
	assign sel_done     = sel_ram1 ? ram1_bank_done : ram2_bank_done;
	assign sel_feedback = sel_ram1 ? ram1_feedback : ram2_feedback;

	// UART writes are dropped, the data just comes back
	always_comb begin
		if (we_q) begin
			uart_word = wdata_q;
		end else if (addr_q == UART_STATUS_ADDR) begin
			uart_word = status_word(rx_ready);
		end else begin
			uart_word = {8'h00, rx_byte};
		end
	end

	////////////////////////////////////////////////////////////
	// Command capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (cmd_valid && cmd_ready) begin
			we_q    <= cmd_we;
			addr_q  <= cmd_addr;
			wdata_q <= cmd_wdata;
			tag_q   <= cmd_tag;
		end
	end

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			state             <= CTRL_IDLE;
			ram1_need_to_work <= 1'b0;
			ram2_need_to_work <= 1'b0;
			uart_data_read    <= 1'b0;
		end else begin
			// Start and read strobes last one cycle
			ram1_need_to_work <= 1'b0;
			ram2_need_to_work <= 1'b0;
			uart_data_read    <= 1'b0;
			case (state)
				CTRL_IDLE: begin
					if (cmd_valid) begin
						if (is_uart_addr(cmd_addr)) begin
							state          <= CTRL_RESPOND;
							uart_data_read <= !cmd_we && (cmd_addr == UART_DATA_ADDR);
						end else begin
							state             <= CTRL_BANK_WAIT;
							ram1_need_to_work <= cmd_addr[BANK_SELECT_BIT];
							ram2_need_to_work <= !cmd_addr[BANK_SELECT_BIT];
						end
					end
				end
				CTRL_BANK_WAIT: begin
					if (sel_done) begin
						state <= CTRL_IDLE;
					end
				end
				CTRL_RESPOND: begin
					state <= CTRL_IDLE;
				end
				default: begin
					state <= CTRL_IDLE;
				end
			endcase
		end
	end

	// Result goes out in the cycle the data is there
	always_comb begin
		case (state)
			CTRL_RESPOND: begin
				done_valid = 1'b1;
				done_rdata = uart_word;
			end
			CTRL_BANK_WAIT: begin
				done_valid = sel_done;
				done_rdata = sel_feedback;
			end
			default: begin
				done_valid = 1'b0;
				done_rdata = sel_feedback;
			end
		endcase
	end

	assign done_tag = tag_q;

endmodule

//--- ram_controller/ram_bank.sv
`timescale 1ns/1ps

module ram_bank #(
	parameter int LATENCY         = 2,
	parameter int BANK_DEPTH_LOG2 = 8
) (
	input  logic                     ram1_work_done,
	input  logic                     reset,

	input  logic                     need_to_work,
	input  logic                     bank_we,
	input  mem_types_pkg::mem_addr_t bank_addr,
	input  mem_types_pkg::mem_word_t bank_wdata,

	output logic                     bank_done,
	output mem_types_pkg::mem_word_t feedback
);

	import mem_types_pkg::*;

	localparam int DEPTH = 2 ** BANK_DEPTH_LOG2;

	// Counter only has to hold LATENCY-1
	localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

	mem_word_t mem [DEPTH];

	logic                       busy;
	logic [CNT_W-1:0]           count;
	logic [BANK_DEPTH_LOG2-1:0] index;

	// Upper address bits are ignored here
	assign index = bank_addr[BANK_DEPTH_LOG2-1:0];

	// Done lands LATENCY cycles after the start pulse
	assign bank_done = busy && (count == '0);

	// Writes echo their data, reads see the stored word
	assign feedback = bank_we ? bank_wdata : mem[index];

	////////////////////////////////////////////////////////////
	// Latency countdown
	////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (need_to_work) begin
			busy  <= 1'b1;
			count <= CNT_W'(LATENCY - 1);
		end else if (busy) begin
			if (count == '0) begin
				busy <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Store happens at the end of the done cycle
	always_ff @(posedge ram1_work_done) begin
		if (bank_done && bank_we) begin
			mem[index] <= bank_wdata;
		end
	end

endmodule

//--- common/mem_map_pkg.sv
package mem_map_pkg;

	// UART registers sit inside the ram1 half of the map
	localparam mem_types_pkg::mem_addr_t UART_DATA_ADDR   = 16'hBF00;
	localparam mem_types_pkg::mem_addr_t UART_STATUS_ADDR = 16'hBF01;

	// Set means ram1 (data RAM), clear means ram2 (instruction RAM)
	localparam int BANK_SELECT_BIT = 15;

	////////////////////////////////////////////////////////////
	// Status word layout, MSB first
	////////////////////////////////////////////////////////////

	localparam logic [11:0] STATUS_FILL = 12'hFFF;
	localparam logic [1:0]  STATUS_MODE = 2'b01;
	localparam logic        STATUS_TAIL = 1'b1;

	function automatic mem_types_pkg::mem_word_t status_word(input logic rx_ready);
		return {STATUS_FILL, STATUS_MODE, rx_ready, STATUS_TAIL};
	endfunction

	function automatic logic is_uart_addr(input mem_types_pkg::mem_addr_t addr);
		return (addr == UART_DATA_ADDR) || (addr == UART_STATUS_ADDR);
	endfunction

endpackage

//--- common/mem_types_pkg.sv
package mem_types_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int WORD_W      = 16;
	localparam int ADDR_W      = 16;
	localparam int UART_BYTE_W = 8;

	// One data word on either bank
	typedef logic [WORD_W-1:0] mem_word_t;

	// Word address, bit 15 selects the bank
	typedef logic [ADDR_W-1:0] mem_addr_t;

	// Received UART byte
	typedef logic [UART_BYTE_W-1:0] uart_byte_t;

	////////////////////////////////////////////////////////////
	// Requester identity
	////////////////////////////////////////////////////////////

	// Travels with each command so the result finds its way home
	typedef logic port_tag_t;

	localparam port_tag_t TAG_FETCH = 1'b0;
	localparam port_tag_t TAG_LS    = 1'b1;

	////////////////////////////////////////////////////////////
	// Controller FSM
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_BANK_WAIT,
		CTRL_RESPOND
	} ctrl_state_t;

endpackage
